// ==== ExecCore.f ====
+incdir+rtl
rtl/ExecCore_pkg.sv
rtl/IssueQueue.sv
rtl/OperandFetch.sv
rtl/IntAlu.sv
rtl/Divider.sv
rtl/Writeback.sv
rtl/ExecCore.sv
testbench/ExecCore_checker.sv
testbench/ExecCore_tb.sv

// ==== rtl/Divider.sv ====
`include "ExecCore_consts.svh"

module Divider import ExecCore_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  ExecUop execUop,
    input  WbBus   aluResult,
    output logic   divBusy,
    output WbBus   divResult
);

    localparam int StepBits = $clog2(`XLEN) + 1;

    logic                busy;
    logic                done;
    logic [StepBits-1:0] stepsLeft;
    logic [`XLEN-1:0]    quot;
    logic [`XLEN-1:0]    rem;
    logic [`XLEN-1:0]    divisor;
    logic [`XLEN:0]      partial;
    logic [`XLEN:0]      trial;
    logic                fits;
    logic                wantRem;
    Tag                  dstTag;
    logic                start;
    logic                step;

    assign start = !busy && execUop.valid && execUop.fu == FU_DIV;
    assign step = busy && !done;

    // one restoring step, remainder shifted left with the next dividend bit
    assign partial = {rem, quot[`XLEN-1]};
    assign fits = partial >= {1'b0, divisor};
    assign trial = partial - {1'b0, divisor};

    assign divBusy = busy;
    assign divResult.valid = done;
    assign divResult.tag = dstTag;
    assign divResult.result = wantRem ? rem : quot;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            done <= 1'b0;
            stepsLeft <= '0;
        end else if (start) begin
            busy <= 1'b1;
            stepsLeft <= StepBits'(`XLEN);
        end else if (step) begin
            stepsLeft <= stepsLeft - 1'b1;
            if (stepsLeft == StepBits'(1)) begin
                done <= 1'b1;
            end
        end else if (done && !aluResult.valid) begin
            busy <= 1'b0; // port taken this cycle.
            done <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            quot <= execUop.srcAVal;
            rem <= '0;
            divisor <= execUop.srcBVal;
            dstTag <= execUop.dst;
            wantRem <= execUop.op.div.isRem;
        end else if (step) begin
            quot <= {quot[`XLEN-2:0], fits}; // zero divisor gives all ones.
            rem <= fits ? trial[`XLEN-1:0] : partial[`XLEN-1:0];
        end
    end

endmodule

// ==== rtl/ExecCore.sv ====
module ExecCore import ExecCore_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       dispatchValid,
    input  DispatchUop dispatchUop,
    output logic       dispatchFull,
    output WbBus       wb
);

    DispatchUop issueUop;
    logic       issueValid;
    ExecUop     execUop;
    WbBus       aluResult;
    WbBus       divResult;
    logic       divBusy;

    IssueQueue issueQueue (
        .clk(clk),
        .reset(reset),
        .dispatchValid(dispatchValid),
        .dispatchUop(dispatchUop),
        .wb(wb),
        .divBusy(divBusy),
        .dispatchFull(dispatchFull),
        .issueValid(issueValid),
        .issueUop(issueUop)
    );

    OperandFetch operandFetch (
        .clk(clk),
        .reset(reset),
        .issueValid(issueValid),
        .issueUop(issueUop),
        .wb(wb),
        .execUop(execUop)
    );

    IntAlu intAlu (
        .clk(clk),
        .reset(reset),
        .execUop(execUop),
        .aluResult(aluResult)
    );

    Divider divider (
        .clk(clk),
        .reset(reset),
        .execUop(execUop),
        .aluResult(aluResult),
        .divBusy(divBusy),
        .divResult(divResult)
    );

    Writeback writeback (
        .clk(clk),
        .reset(reset),
        .aluResult(aluResult),
        .divResult(divResult),
        .wb(wb)
    );

endmodule

// ==== rtl/ExecCore_consts.svh ====
`ifndef EXECCORE_CONSTS_SVH
`define EXECCORE_CONSTS_SVH

// data path width.
`define XLEN 32

// physical register file.
`define NUM_PREGS 32
`define PREG_BITS 5

// issue queue entries.
`define IQ_SIZE 8

`endif

// ==== rtl/ExecCore_pkg.sv ====
`include "ExecCore_consts.svh"

package ExecCore_pkg;

    typedef logic [`PREG_BITS-1:0] Tag;

    typedef enum logic {
        FU_ALU,
        FU_DIV
    } FuType;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLTU
    } AluOp;

    typedef struct packed {
        logic [1:0] pad;
        logic       isRem; // remu when set, divu otherwise.
    } DivOp;

    // meaning depends on the fu field next to it.
    typedef union packed {
        AluOp alu;
        DivOp div;
    } OpCode;

    typedef struct packed {
        FuType fu;
        OpCode op;
        Tag    srcA;
        Tag    srcB;
        Tag    dst;
    } DispatchUop;

    typedef struct packed {
        logic             valid;
        FuType            fu;
        OpCode            op;
        Tag               dst;
        logic [`XLEN-1:0] srcAVal;
        logic [`XLEN-1:0] srcBVal;
    } ExecUop;

    typedef struct packed {
        logic             valid;
        Tag               tag;
        logic [`XLEN-1:0] result;
    } WbBus;

endpackage

// ==== rtl/IntAlu.sv ====
`include "ExecCore_consts.svh"

module IntAlu import ExecCore_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  ExecUop execUop,
    output WbBus   aluResult
);

    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] value;

    assign a = execUop.srcAVal;
    assign b = execUop.srcBVal;

    always_comb begin
        case (execUop.op.alu)
            ADD:     value = a + b;
            SUB:     value = a - b;
            AND:     value = a & b;
            OR:      value = a | b;
            XOR:     value = a ^ b;
            SLTU:    value = {{(`XLEN - 1){1'b0}}, a < b};
            default: value = a + b; // unused encodings.
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            aluResult.valid <= 1'b0;
        end else begin
            aluResult.valid <= execUop.valid && execUop.fu == FU_ALU;
        end
    end

    always_ff @(posedge clk) begin
        aluResult.tag <= execUop.dst;
        aluResult.result <= value;
    end

endmodule

// ==== rtl/IssueQueue.sv ====
`include "ExecCore_consts.svh"

module IssueQueue import ExecCore_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       dispatchValid,
    input  DispatchUop dispatchUop,
    input  WbBus       wb,
    input  logic       divBusy,
    output logic       dispatchFull,
    output logic       issueValid,
    output DispatchUop issueUop
);

    localparam int IdxBits = $clog2(`IQ_SIZE);
    localparam int CntBits = IdxBits + 1;

    DispatchUop            entries [`IQ_SIZE]; // index 0 is the oldest.
    logic [CntBits-1:0]    count;
    logic [CntBits-1:0]    tailPos;
    logic [IdxBits-1:0]    issueIdx;
    logic [`NUM_PREGS-1:0] regReady;
    logic [`NUM_PREGS-1:0] readyNow;
    logic                  divInFetch;
    logic                  divBlocked;

    assign dispatchFull = count == CntBits'(`IQ_SIZE);
    assign divBlocked = divBusy || divInFetch;
    assign tailPos = count - CntBits'(issueValid); // slot after the shift.
    assign issueUop = entries[issueIdx];

    always_comb begin
        readyNow = regReady;
        if (wb.valid) begin
            readyNow[wb.tag] = 1'b1; // same-cycle wakeup.
        end
    end

    // walk down so the lowest, oldest eligible slot is the one kept
    always_comb begin
        issueValid = 1'b0;
        issueIdx = '0;
        for (int i = `IQ_SIZE - 1; i >= 0; i--) begin
            if (CntBits'(i) < count
                    && readyNow[entries[i].srcA]
                    && readyNow[entries[i].srcB]
                    && (entries[i].fu != FU_DIV || !divBlocked)) begin
                issueValid = 1'b1;
                issueIdx = IdxBits'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
            regReady <= '1;
            divInFetch <= 1'b0;
        end else begin
            count <= tailPos + CntBits'(dispatchValid);
            divInFetch <= issueValid && issueUop.fu == FU_DIV;
            if (wb.valid) begin
                regReady[wb.tag] <= 1'b1;
            end
            if (dispatchValid) begin
                regReady[dispatchUop.dst] <= 1'b0; // new writer overrides wakeup.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issueValid) begin
            for (int i = 0; i < `IQ_SIZE - 1; i++) begin
                if (IdxBits'(i) >= issueIdx) begin
                    entries[i] <= entries[i + 1]; // close the gap.
                end
            end
        end
        if (dispatchValid) begin
            entries[tailPos[IdxBits-1:0]] <= dispatchUop;
        end
    end

endmodule

// ==== rtl/OperandFetch.sv ====
`include "ExecCore_consts.svh"

module OperandFetch import ExecCore_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       issueValid,
    input  DispatchUop issueUop,
    input  WbBus       wb,
    output ExecUop     execUop
);

    logic [`XLEN-1:0] regFile [`NUM_PREGS];

    // writeback in flight this cycle wins over the stored value
    function automatic logic [`XLEN-1:0] readReg(Tag t);
        if (wb.valid && wb.tag == t) begin
            return wb.result;
        end
        return regFile[t];
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NUM_PREGS; i++) begin
                regFile[i] <= '0; // all registers read as zero.
            end
        end else if (wb.valid) begin
            regFile[wb.tag] <= wb.result;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            execUop.valid <= 1'b0;
        end else begin
            execUop.valid <= issueValid;
        end
    end

    always_ff @(posedge clk) begin
        execUop.fu <= issueUop.fu;
        execUop.op <= issueUop.op;
        execUop.dst <= issueUop.dst;
        execUop.srcAVal <= readReg(issueUop.srcA);
        execUop.srcBVal <= readReg(issueUop.srcB);
    end

endmodule

// ==== rtl/Writeback.sv ====
module Writeback import ExecCore_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  WbBus aluResult,
    input  WbBus divResult,
    output WbBus wb
);

    WbBus winner;

    assign winner = aluResult.valid ? aluResult : divResult; // alu first.

    always_ff @(posedge clk) begin
        if (reset) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= winner.valid;
        end
    end

    always_ff @(posedge clk) begin
        wb.tag <= winner.tag;
        wb.result <= winner.result;
    end

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module ExecCore_tb -f ExecCore.f
./obj_dir/VExecCore_tb

// ==== testbench/ExecCore_checker.sv ====
module ExecCore_checker import ExecCore_pkg::*; (
    input logic clk,
    input logic reset,
    input logic dispatchValid,
    input logic dispatchFull,
    input WbBus wb
);

    timeunit 1ns;
    timeprecision 100ps;

    // the environment must hold off dispatch while the queue is full
    noDispatchWhenFull: assert property (@(posedge clk) disable iff (reset)
        dispatchValid |-> !dispatchFull)
        else $error("dispatch offered while the issue queue is full");

    wbValidKnown: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(wb.valid))
        else $error("wb.valid is unknown after reset");

    wbTagKnown: assert property (@(posedge clk) disable iff (reset)
        wb.valid |-> !$isunknown(wb.tag))
        else $error("wb.tag is unknown on a writeback");

endmodule

// ==== testbench/ExecCore_tb.sv ====
`include "ExecCore_consts.svh"

module ExecCore_tb import ExecCore_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int Timeout = 2000; // cycles allowed per wait.

    logic       clk;
    logic       reset;
    logic       dispatchValid;
    DispatchUop dispatchUop;
    logic       dispatchFull;
    WbBus       wb;

    logic [15:0]      lfsrState;
    logic [`XLEN-1:0] expReg [`NUM_PREGS]; // value after every dispatched write.
    bit               inFlight [`NUM_PREGS];
    int               readers [`NUM_PREGS]; // pending micro-ops reading a tag.
    DispatchUop       sentUop [`NUM_PREGS];
    string            nameOf [`NUM_PREGS];
    int               pending;

    ExecCore dut_i (.*);

    bind ExecCore ExecCore_checker checker_i (
        .clk(clk), .reset(reset), .dispatchValid(dispatchValid),
        .dispatchFull(dispatchFull), .wb(wb)
    );

    always #4 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [31:0] randBits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsrState[0]};
            lfsrState = lfsrState[0] ? (lfsrState >> 1) ^ 16'hB400 : lfsrState >> 1;
        end
        return r;
    endfunction

    function automatic OpCode makeOp(FuType fu, int code);
        OpCode op;
        if (fu == FU_DIV) begin
            op.div.pad = 2'b00;
            op.div.isRem = code[0];
        end else begin
            op.alu = AluOp'(code);
        end
        return op;
    endfunction

    function automatic OpCode randAluOp();
        return makeOp(FU_ALU, int'(randBits(3) % 6));
    endfunction

    function automatic logic [`XLEN-1:0] refResult(FuType fu, OpCode op,
                                                   logic [`XLEN-1:0] a, logic [`XLEN-1:0] b);
        if (fu == FU_DIV) begin
            if (b == '0) begin
                return op.div.isRem ? a : '1; // divide by zero.
            end
            return op.div.isRem ? a % b : a / b;
        end
        case (op.alu)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLTU:    return (a < b) ? 1 : 0;
            default: return 'x;
        endcase
    endfunction

    function automatic Tag readyTag();
        Tag t;
        t = Tag'(randBits(`PREG_BITS));
        while (inFlight[t]) begin
            t = t + 1'b1;
        end
        return t;
    endfunction

    // a destination needs no writer in flight and no reader still waiting on it
    function automatic int freeTag(Tag a, Tag b);
        Tag t;
        t = Tag'(randBits(`PREG_BITS));
        for (int i = 0; i < `NUM_PREGS; i++) begin
            if (!inFlight[t] && readers[t] == 0 && t != a && t != b) begin
                return int'(t);
            end
            t = t + 1'b1;
        end
        return -1;
    endfunction

    task automatic abortRun(string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic checkWb(string name, WbBus expWb, WbBus actWb);
        if (actWb.valid !== expWb.valid || actWb.tag !== expWb.tag
                || actWb.result !== expWb.result) begin
            abortRun($sformatf("MISMATCH %s: expected tag %0d result %h, actual tag %0d result %h",
                               name, expWb.tag, expWb.result, actWb.tag, actWb.result));
        end
    endtask

    task automatic checkFull(string name, logic expFull, logic actFull);
        if (actFull !== expFull) begin
            abortRun($sformatf("MISMATCH %s: expected dispatchFull %b, actual %b",
                               name, expFull, actFull));
        end
    endtask

    task automatic sendUop(input string name, input FuType fu, input OpCode op,
                           input Tag srcA, input Tag srcB, output Tag dst);
        int waited;
        int pick;
        waited = 0;
        pick = -1;
        while (pick < 0) begin
            @(posedge clk);
            if (!dispatchFull) begin
                pick = freeTag(srcA, srcB);
            end
            waited++;
            if (waited > Timeout) begin
                abortRun($sformatf("%s: no free queue slot or destination tag", name));
            end
        end
        dst = Tag'(pick);
        sentUop[dst] = '{fu: fu, op: op, srcA: srcA, srcB: srcB, dst: dst};
        expReg[dst] = refResult(fu, op, expReg[srcA], expReg[srcB]);
        inFlight[dst] = 1'b1;
        readers[srcA]++;
        readers[srcB]++;
        nameOf[dst] = name;
        pending++;
        dispatchValid <= 1'b1;
        dispatchUop <= sentUop[dst];
        @(posedge clk);
        dispatchValid <= 1'b0; // accepted on this edge.
    endtask

    task automatic waitPending(string name, int level);
        int waited;
        waited = 0;
        while (pending > level) begin
            @(posedge clk);
            waited++;
            if (waited > Timeout) begin
                abortRun($sformatf("%s: %0d results never written back", name, pending));
            end
        end
    endtask

    always @(negedge clk) begin
        WbBus expWb;
        if (!reset && wb.valid) begin
            if (!inFlight[wb.tag]) begin
                abortRun($sformatf("writeback to tag %0d with no micro-op in flight", wb.tag));
            end
            expWb = '{valid: 1'b1, tag: wb.tag, result: expReg[wb.tag]};
            checkWb(nameOf[wb.tag], expWb, wb);
            inFlight[wb.tag] = 1'b0;
            readers[sentUop[wb.tag].srcA]--;
            readers[sentUop[wb.tag].srcB]--;
            pending--;
        end
    end

    initial begin
        Tag t;
        Tag a;
        Tag b;
        Tag divTag;
        clk = 1'b0;
        reset = 1'b1;
        dispatchValid = 1'b0;
        dispatchUop = '0;
        lfsrState = 16'd60753;
        pending = 0;
        for (int i = 0; i < `NUM_PREGS; i++) begin
            expReg[i] = '0;
            inFlight[i] = 1'b0;
            readers[i] = 0;
        end
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        if (wb.valid !== 1'b0) begin
            abortRun("wb.valid is not low after reset");
        end
        checkFull("afterReset", 1'b0, dispatchFull);
        for (int i = 0; i < `NUM_PREGS; i++) begin
            sendUop("readZero", FU_ALU, makeOp(FU_ALU, ADD), Tag'(i), Tag'(i), t);
        end
        waitPending("readZero", 0);
        // 0 / 0 gives all ones, and 0 < all ones gives one.
        sendUop("seedOnes", FU_DIV, makeOp(FU_DIV, 0), readyTag(), readyTag(), a);
        sendUop("seedOne", FU_ALU, makeOp(FU_ALU, SLTU), readyTag(), a, t);
        repeat (24) begin
            sendUop("independentAlu", FU_ALU, randAluOp(), readyTag(), readyTag(), t);
        end
        a = readyTag();
        repeat (16) begin
            sendUop("dependentChain", FU_ALU, randAluOp(), a, Tag'(randBits(`PREG_BITS)), a);
        end
        waitPending("dependentChain", 0);
        a = readyTag();
        sendUop("makeZero", FU_ALU, makeOp(FU_ALU, SUB), a, a, t);
        a = readyTag();
        b = readyTag();
        for (int k = 0; k < 2; k++) begin
            sendUop("divRandom", FU_DIV, makeOp(FU_DIV, k), a, b, divTag);
            sendUop("divByZero", FU_DIV, makeOp(FU_DIV, k), a, t, divTag);
            if (expReg[a] < expReg[b]) begin
                sendUop("divSmall", FU_DIV, makeOp(FU_DIV, k), a, b, divTag);
            end else begin
                sendUop("divSmall", FU_DIV, makeOp(FU_DIV, k), b, a, divTag);
            end
        end
        waitPending("divides", 0);
        sendUop("divPending", FU_DIV, makeOp(FU_DIV, 0), readyTag(), readyTag(), divTag);
        repeat (12) begin
            sendUop("aluStream", FU_ALU, randAluOp(), readyTag(), readyTag(), t);
        end
        waitPending("aluStream", 1);
        if (!inFlight[divTag]) begin
            abortRun("divide result was written back before the ALU stream finished");
        end
        waitPending("divPending", 0);
        sendUop("fillQueue", FU_DIV, makeOp(FU_DIV, 1), readyTag(), readyTag(), divTag);
        repeat (`IQ_SIZE) begin
            sendUop("fillQueue", FU_ALU, randAluOp(), divTag, Tag'(randBits(`PREG_BITS)), t);
        end
        @(negedge clk);
        checkFull("fillQueue", 1'b1, dispatchFull);
        waitPending("drainQueue", 0);
        @(negedge clk);
        checkFull("drainQueue", 1'b0, dispatchFull);
        $display("Test OK");
        $finish;
    end

endmodule
